//--- src/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// geometry
`define CACHE_WAYS 2
`define WAY_BITS 1 // log2 of ways
`define CACHE_SETS 16

// address split, tag | set | offset
`define OFFSET_BITS 4
`define SET_BITS 4
`define TAG_BITS 8
`define ADDR_BITS 16

// data widths
`define LINE_BITS 128 // 16 bytes per line
`define WORD_BITS 32

`endif

//--- src/cachePkg.sv
`include "cache_cfg.svh"

package cachePkg;

  typedef logic [`ADDR_BITS-1:0] addrT;
  typedef logic [`TAG_BITS-1:0] tagT;
  typedef logic [`SET_BITS-1:0] setT;
  typedef logic [`OFFSET_BITS-1:0] offsetT;
  typedef logic [`TAG_BITS+`SET_BITS-1:0] lineAddrT; // memory line address
  typedef logic [`LINE_BITS-1:0] lineT;
  typedef logic [`WORD_BITS-1:0] wordT;

  typedef enum logic [2:0] {
    opRead8   = 3'd0,
    opRead16  = 3'd1,
    opRead32  = 3'd2,
    opWrite8  = 3'd3,
    opWrite16 = 3'd4,
    opWrite32 = 3'd5
  } cpuOpT;

  typedef struct packed {
    cpuOpT op;
    addrT  addr;
    wordT  wdata;
  } cpuCmdT;

  typedef struct packed {
    logic     write; // 1 = write-back, 0 = refill read
    lineAddrT lineAddr;
    lineT     wline;
  } memCmdT;

  // broadcast to every way, the one-hot enable picks the target
  typedef struct packed {
    logic en;
    setT  set;
    tagT  tag;
    logic valid;
    logic dirty;
    lineT line;
  } wayWriteT;

  typedef struct packed {
    logic hit;
    logic valid;
    logic dirty;
    tagT  tag;
    lineT line;
  } wayStatusT;

  typedef enum logic [2:0] {
    stIdle,
    stLookup,
    stWriteBack,
    stRefill,
    stRespond
  } ctrlStateT;

endpackage

//--- src/cacheWay.sv
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cacheWay (
  input  logic                 RESET,
  input  logic                 rstN,
  input  cachePkg::setT        lookupSet,
  input  cachePkg::tagT        lookupTag,
  input  cachePkg::wayWriteT   wayWrite,
  input  logic                 wen,
  output cachePkg::wayStatusT  status
);
  import cachePkg::*;

  tagT tagMem [`CACHE_SETS];
  lineT lineMem [`CACHE_SETS];
  logic [`CACHE_SETS-1:0] validBits;
  logic [`CACHE_SETS-1:0] dirtyBits;
  logic doWrite;
  tagT entryTag;
  logic entryValid;

  assign doWrite = wen && wayWrite.en;

  always_ff @(posedge RESET or negedge rstN) begin
    if (!rstN) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (doWrite) begin
      validBits[wayWrite.set] <= wayWrite.valid;
      dirtyBits[wayWrite.set] <= wayWrite.dirty;
    end
  end

  always_ff @(posedge RESET) begin
    if (doWrite) begin
      tagMem[wayWrite.set] <= wayWrite.tag;
      lineMem[wayWrite.set] <= wayWrite.line;
    end
  end

  // lookup is combinational off the stored entry
  assign entryTag = tagMem[lookupSet];
  assign entryValid = validBits[lookupSet];

  assign status.hit = entryValid && (entryTag == lookupTag);
  assign status.valid = entryValid;
  assign status.dirty = dirtyBits[lookupSet];
  assign status.tag = entryTag;
  assign status.line = lineMem[lookupSet];

endmodule

//--- src/hitSelect.sv
`timescale 1ns/100ps
`include "cache_cfg.svh"

module hitSelect (
  input  logic                                   RESET,
  input  logic                                   rstN,
  input  cachePkg::setT                          lookupSet,
  input  cachePkg::offsetT                       offset,
  input  cachePkg::cpuOpT                        op,
  input  cachePkg::wayStatusT [`CACHE_WAYS-1:0]  status,
  input  logic                                   touch,
  input  logic [`WAY_BITS-1:0]                   touchWay,
  output logic                                   hit,
  output logic [`WAY_BITS-1:0]                   hitWay,
  output logic [`WAY_BITS-1:0]                   victimWay,
  output cachePkg::lineT                         selLine,
  output cachePkg::tagT                          victimTag,
  output logic                                   victimDirty,
  output cachePkg::wordT                         rdata
);
  import cachePkg::*;

  logic [`CACHE_SETS-1:0] lruBits; // way used last, per set
  lineT shiftedLine;

  always_ff @(posedge RESET or negedge rstN) begin
    if (!rstN) begin
      lruBits <= '0;
    end else if (touch) begin
      lruBits[lookupSet] <= touchWay;
    end
  end

  always_comb begin
    hit = 1'b0;
    hitWay = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (status[w].hit) begin
        hit = 1'b1;
        hitWay = `WAY_BITS'(w);
      end
    end
  end

  // two ways, so the victim is simply the other one
  assign victimWay = ~lruBits[lookupSet];
  assign victimTag = status[victimWay].tag;
  assign victimDirty = status[victimWay].valid && status[victimWay].dirty;

  assign selLine = hit ? status[hitWay].line : status[victimWay].line;

  // little endian within the line
  assign shiftedLine = selLine >> {offset, 3'b000};

  always_comb begin
    case (op)
      opRead8:  rdata = wordT'(shiftedLine[7:0]);
      opRead16: rdata = wordT'(shiftedLine[15:0]);
      opRead32: rdata = shiftedLine[`WORD_BITS-1:0];
      default:  rdata = '0; // writes return nothing
    endcase
  end

endmodule

//--- src/cacheCtrl.sv
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cacheCtrl (
  input  logic                  RESET,
  input  logic                  rstN,
  input  logic                  cpuReq,
  input  cachePkg::cpuCmdT      cpuCmd,
  output logic                  cpuAck,
  output cachePkg::wordT        cpuRdata,
  output logic                  memReq,
  output cachePkg::memCmdT      memCmd,
  input  logic                  memAck,
  input  cachePkg::lineT        memRline,
  output cachePkg::setT         lookupSet,
  output cachePkg::tagT         lookupTag,
  output cachePkg::wayWriteT    wayWrite,
  output logic [`CACHE_WAYS-1:0] wayWen,
  input  logic                  hit,
  input  logic [`WAY_BITS-1:0]  hitWay,
  input  logic [`WAY_BITS-1:0]  victimWay,
  input  cachePkg::lineT        selLine,
  input  cachePkg::tagT         victimTag,
  input  logic                  victimDirty,
  input  cachePkg::wordT        rdata,
  output logic                  touch,
  output logic [`WAY_BITS-1:0]  touchWay
);
  import cachePkg::*;

  ctrlStateT state;
  cpuCmdT reqReg;
  tagT reqTag;
  setT reqSet;
  logic isWrite;

  // drop the CPU bytes into the line at the byte offset
  function automatic lineT mergeLine(lineT line, cpuCmdT cmd);
    lineT merged;
    int unsigned base;
    merged = line;
    base = {cmd.addr[`OFFSET_BITS-1:0], 3'b000};
    case (cmd.op)
      opWrite8:  merged[base +: 8] = cmd.wdata[7:0];
      opWrite16: merged[base +: 16] = cmd.wdata[15:0];
      opWrite32: merged[base +: 32] = cmd.wdata;
      default:   merged = line;
    endcase
    return merged;
  endfunction

  assign reqTag = reqReg.addr[`ADDR_BITS-1 -: `TAG_BITS];
  assign reqSet = reqReg.addr[`OFFSET_BITS +: `SET_BITS];
  assign lookupSet = reqSet;
  assign lookupTag = reqTag;
  assign isWrite = reqReg.op inside {opWrite8, opWrite16, opWrite32};

  always_ff @(posedge RESET or negedge rstN) begin
    if (!rstN) begin
      state <= stIdle;
      cpuAck <= 1'b0;
      memReq <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          if (cpuReq) state <= stLookup;
        end
        stLookup: begin
          if (hit) begin
            state <= stRespond;
          end else if (victimDirty) begin
            state <= stWriteBack;
            memReq <= 1'b1;
          end else begin
            state <= stRefill;
            memReq <= 1'b1;
          end
        end
        stWriteBack: begin
          if (memReq) begin
            if (memAck) memReq <= 1'b0;
          end else if (!memAck) begin // handshake closed, start refill
            memReq <= 1'b1;
            state <= stRefill;
          end
        end
        stRefill: begin
          if (memReq) begin
            if (memAck) memReq <= 1'b0; // line written this edge
          end else if (!memAck) begin
            state <= stLookup; // now hits
          end
        end
        stRespond: begin
          if (!cpuAck) begin
            cpuAck <= 1'b1;
          end else if (!cpuReq) begin
            cpuAck <= 1'b0;
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge RESET) begin
    if (state == stIdle && cpuReq) reqReg <= cpuCmd;
    if (state == stRespond && !cpuAck) cpuRdata <= rdata;
    if (state == stLookup && !hit) begin
      if (victimDirty) begin
        memCmd <= '{write: 1'b1, lineAddr: {victimTag, reqSet}, wline: selLine};
      end else begin
        memCmd <= '{write: 1'b0, lineAddr: {reqTag, reqSet}, wline: '0};
      end
    end
    if (state == stWriteBack && !memReq && !memAck) begin
      memCmd <= '{write: 1'b0, lineAddr: {reqTag, reqSet}, wline: '0};
    end
  end

  always_comb begin
    wayWrite = '0;
    wayWen = '0;
    touch = 1'b0;
    touchWay = hitWay;
    if (state == stLookup && hit) begin
      touch = 1'b1;
      if (isWrite) begin
        wayWrite = '{en: 1'b1, set: reqSet, tag: reqTag, valid: 1'b1, dirty: 1'b1,
                     line: mergeLine(selLine, reqReg)};
        wayWen[hitWay] = 1'b1;
      end
    end else if (state == stRefill && memReq && memAck) begin
      // fresh line goes in clean, a write merges on the repeat lookup
      wayWrite = '{en: 1'b1, set: reqSet, tag: reqTag, valid: 1'b1, dirty: 1'b0,
                   line: memRline};
      wayWen[victimWay] = 1'b1;
    end
  end

endmodule

//--- src/cacheTop.sv
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cacheTop (
  input  logic              RESET,
  input  logic              rstN,
  input  logic              cpuReq,
  input  cachePkg::cpuCmdT  cpuCmd,
  output logic              cpuAck,
  output cachePkg::wordT    cpuRdata,
  output logic              memReq,
  output cachePkg::memCmdT  memCmd,
  input  logic              memAck,
  input  cachePkg::lineT    memRline
);
  import cachePkg::*;

  setT lookupSet;
  tagT lookupTag;
  wayWriteT wayWrite;
  logic [`CACHE_WAYS-1:0] wayWen;
  wayStatusT [`CACHE_WAYS-1:0] wayStatus;

  logic hit;
  logic [`WAY_BITS-1:0] hitWay;
  logic [`WAY_BITS-1:0] victimWay;
  lineT selLine;
  tagT victimTag;
  logic victimDirty;
  wordT rdata;
  logic touch;
  logic [`WAY_BITS-1:0] touchWay;

  cacheCtrl uCtrl (
    .RESET, .rstN,
    .cpuReq, .cpuCmd, .cpuAck, .cpuRdata,
    .memReq, .memCmd, .memAck, .memRline,
    .lookupSet, .lookupTag, .wayWrite, .wayWen,
    .hit, .hitWay, .victimWay, .selLine, .victimTag, .victimDirty, .rdata,
    .touch, .touchWay
  );

  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : gWay
    cacheWay uWay (
      .RESET, .rstN,
      .lookupSet, .lookupTag,
      .wayWrite,
      .wen(wayWen[w]),
      .status(wayStatus[w])
    );
  end

  // cpuCmd holds still until cpuAck, so offset and op come straight off the port
  hitSelect uHitSel (
    .RESET, .rstN,
    .lookupSet,
    .offset(cpuCmd.addr[`OFFSET_BITS-1:0]),
    .op(cpuCmd.op),
    .status(wayStatus),
    .touch, .touchWay,
    .hit, .hitWay, .victimWay, .selLine, .victimTag, .victimDirty, .rdata
  );

endmodule

//--- test/cacheChecker.sv
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cacheChecker (
  input  logic              RESET,
  input  logic              rstN,
  input  logic              cpuReq,
  input  cachePkg::cpuCmdT  cpuCmd,
  input  logic              cpuAck,
  input  cachePkg::wordT    cpuRdata,
  input  logic              memReq,
  input  cachePkg::memCmdT  memCmd,
  input  logic [1:0]        expKind,
  output int                errCount,
  output int                checkCount
);
  import cachePkg::*;

  localparam logic [1:0] KindHit = 2'd0;
  localparam logic [1:0] KindMissClean = 2'd1;
  localparam logic [1:0] KindMissDirty = 2'd2;
  localparam logic [1:0] KindAny = 2'd3;

  logic [7:0] image [0:(1 << `ADDR_BITS)-1]; // bytes as the CPU should see them
  tagT tagM [`CACHE_WAYS][`CACHE_SETS];
  logic validM [`CACHE_WAYS][`CACHE_SETS];
  logic dirtyM [`CACHE_WAYS][`CACHE_SETS];
  int lruM [`CACHE_SETS]; // way used last
  memCmdT expMem [2];
  int expMemCount;
  int memSeen;
  logic memReqLast;
  logic busy;
  logic isRead;
  logic [1:0] kind;
  logic [1:0] seenKind;
  int cycles;
  wordT expRdata;

  function automatic logic [7:0] initialByte(addrT a);
    logic [15:0] p;
    p = a * 7 + 3;
    return p[7:0] ^ a[15:8];
  endfunction

  function automatic lineT imageLine(tagT t, setT s);
    lineT l;
    for (int b = 0; b < `LINE_BITS / 8; b++) begin
      l[b*8 +: 8] = image[{t, s, offsetT'(b)}];
    end
    return l;
  endfunction

  task automatic verify(input logic ok, input string msg);
    checkCount++;
    if (!ok) begin
      errCount++;
      $display("CHECK FAILED at %0d ns: %s", $time, msg);
    end
  endtask

  task automatic startRequest();
    tagT t;
    setT s;
    int way;
    int n;
    t = cpuCmd.addr[`ADDR_BITS-1 -: `TAG_BITS];
    s = cpuCmd.addr[`OFFSET_BITS +: `SET_BITS];
    way = -1;
    expMemCount = 0;
    memSeen = 0;
    kind = KindHit;
    seenKind = KindHit;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (validM[w][s] && tagM[w][s] == t) way = w;
    end
    if (way < 0) begin
      way = (lruM[s] + 1) % `CACHE_WAYS; // not used last
      kind = KindMissClean;
      if (validM[way][s] && dirtyM[way][s]) begin
        kind = KindMissDirty;
        expMem[0] = '{write: 1'b1, lineAddr: {tagM[way][s], s},
                      wline: imageLine(tagM[way][s], s)};
        expMemCount = 1;
      end
      expMem[expMemCount] = '{write: 1'b0, lineAddr: {t, s}, wline: '0};
      expMemCount++;
      tagM[way][s] = t;
      validM[way][s] = 1'b1;
      dirtyM[way][s] = 1'b0;
    end
    lruM[s] = way;
    n = cpuCmd.op inside {opRead8, opWrite8} ? 1 : cpuCmd.op inside {opRead16, opWrite16} ? 2 : 4;
    isRead = cpuCmd.op inside {opRead8, opRead16, opRead32};
    expRdata = '0;
    for (int b = 0; b < n; b++) begin
      if (isRead) expRdata[b*8 +: 8] = image[cpuCmd.addr + b];
      else image[cpuCmd.addr + b] = cpuCmd.wdata[b*8 +: 8];
    end
    if (!isRead) dirtyM[way][s] = 1'b1;
    busy = 1'b1;
    cycles = 0;
  endtask

  task automatic checkMemReq();
    if (!busy || memSeen >= expMemCount) begin
      verify(1'b0, $sformatf("unexpected memory request, write %b line %h",
                             memCmd.write, memCmd.lineAddr));
    end else begin
      verify(memCmd.write == expMem[memSeen].write
             && memCmd.lineAddr == expMem[memSeen].lineAddr
             && (!memCmd.write || memCmd.wline == expMem[memSeen].wline),
             $sformatf("memory request write %b line %h, expected write %b line %h",
                       memCmd.write, memCmd.lineAddr,
                       expMem[memSeen].write, expMem[memSeen].lineAddr));
    end
    if (memSeen == 0) seenKind = memCmd.write ? KindMissDirty : KindMissClean;
    memSeen++;
  endtask

  task automatic finishRequest();
    verify(memSeen == expMemCount, $sformatf("%0d memory requests for %h, expected %0d",
                                             memSeen, cpuCmd.addr, expMemCount));
    if (expKind != KindAny) begin
      verify(expKind == seenKind, $sformatf("table outcome %0d, observed outcome %0d at %h",
                                            expKind, seenKind, cpuCmd.addr));
    end
    // request sampled at the next rise and acked two rises later
    if (kind == KindHit) begin
      verify(cycles == 3, $sformatf("hit at %h acked after %0d edges", cpuCmd.addr, cycles));
    end
    if (isRead) begin
      verify(cpuRdata == expRdata, $sformatf("read at %h gave %h, expected %h",
                                             cpuCmd.addr, cpuRdata, expRdata));
    end
    busy = 1'b0;
  endtask

  initial begin
    errCount = 0;
    checkCount = 0;
    busy = 1'b0;
    memReqLast = 1'b0;
    for (int a = 0; a < (1 << `ADDR_BITS); a++) begin
      image[a] = initialByte(addrT'(a));
    end
  end

  always @(negedge RESET) begin
    if (!rstN) begin
      verify(!cpuAck && !memReq, "cpuAck or memReq high during reset");
      for (int s = 0; s < `CACHE_SETS; s++) begin
        lruM[s] = 0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          validM[w][s] = 1'b0;
          dirtyM[w][s] = 1'b0;
        end
      end
      busy = 1'b0;
    end else begin
      if (memReq && !memReqLast) checkMemReq();
      if (busy) begin
        cycles++;
        if (cpuAck) finishRequest();
      end else if (cpuReq && !cpuAck) begin
        startRequest();
      end
    end
    memReqLast = memReq;
  end

endmodule

//--- test/tbTop.sv
`timescale 1ns/100ps
`include "cache_cfg.svh"

module tbTop;
  import cachePkg::*;

  localparam int RandCount = 32;
  localparam int WaitLimit = 200; // cycles per handshake wait

  typedef enum logic [1:0] {kHit, kMissClean, kMissDirty, kAny} kindT;

  typedef struct packed {
    cpuOpT op;
    addrT  addr;
    wordT  wdata;
    kindT  kind; // expected outcome or kAny for random entries
  } stimT;

  logic RESET;
  logic rstN;
  logic cpuReq;
  cpuCmdT cpuCmd;
  logic cpuAck;
  wordT cpuRdata;
  logic memReq;
  memCmdT memCmd;
  logic memAck;
  lineT memRline;
  kindT expKind;
  int errCount;
  int checkCount;
  int timeoutCount;
  int memWait;
  logic [31:0] lfsr;
  logic [7:0] memBytes [0:(1 << `ADDR_BITS)-1];
  stimT stim [$];

  cacheTop uut (
    .RESET, .rstN,
    .cpuReq, .cpuCmd, .cpuAck, .cpuRdata,
    .memReq, .memCmd, .memAck, .memRline
  );

  cacheChecker uChk (
    .RESET, .rstN,
    .cpuReq, .cpuCmd, .cpuAck, .cpuRdata,
    .memReq, .memCmd,
    .expKind(expKind),
    .errCount, .checkCount
  );

  always #2 RESET = ~RESET;

  // low byte of a*7+3 with the tag byte folded in so lines of a set differ
  function automatic logic [7:0] fillByte(addrT a);
    logic [15:0] scaled;
    scaled = a * 7 + 3;
    return scaled[7:0] ^ a[15:8];
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] takeBits(int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  task automatic addStim(cpuOpT op, addrT addr, wordT wdata, kindT kind);
    stimT s;
    s = '{op: op, addr: addr, wdata: wdata, kind: kind};
    stim.push_back(s);
  endtask

  task automatic buildTable();
    logic [31:0] r;
    logic [31:0] d;
    cpuOpT op;
    addrT a;
    // set 1 with tags 12, 34 and 56
    addStim(opRead32, 16'h1210, '0, kMissClean);
    addStim(opRead8, 16'h1213, '0, kHit);
    addStim(opRead16, 16'h1216, '0, kHit);
    addStim(opWrite32, 16'h1218, 32'hdeadbeef, kHit);
    addStim(opRead32, 16'h1218, '0, kHit);
    addStim(opWrite8, 16'h1219, 32'h123456a5, kHit);
    addStim(opRead32, 16'h1218, '0, kHit); // neighbours of the byte write
    addStim(opRead32, 16'h341c, '0, kMissClean);
    addStim(opRead32, 16'h5610, '0, kMissDirty); // written line goes back
    addStim(opRead32, 16'h1218, '0, kMissClean);
    addStim(opWrite16, 16'h341e, 32'h55aa7788, kMissClean);
    addStim(opRead32, 16'h341c, '0, kHit);
    addStim(opRead8, 16'h5613, '0, kMissClean);
    addStim(opRead8, 16'h1210, '0, kMissDirty);
    addStim(opWrite8, 16'h0a27, 32'h0000003c, kMissClean);
    addStim(opRead32, 16'h0a24, '0, kHit);
    addStim(opRead16, 16'h0002, '0, kMissClean);
    for (int i = 0; i < RandCount; i++) begin
      r = takeBits(3);
      op = cpuOpT'(r[2:0] % 3'd6);
      r = takeBits(8);
      a = {6'b100110, r[7:6], 2'b11, r[5:4], r[3:0]}; // 4 tags over sets 12 to 15
      if (op inside {opRead16, opWrite16}) a[0] = 1'b0;
      if (op inside {opRead32, opWrite32}) a[1:0] = 2'b00;
      d = takeBits(32);
      addStim(op, a, d, kAny);
    end
  endtask

  // called 1 ns after an edge with cpuAck low
  task automatic runAccess(input stimT s, output logic ok);
    int n;
    ok = 1'b1;
    cpuCmd = '{op: s.op, addr: s.addr, wdata: s.wdata};
    expKind = s.kind;
    cpuReq = 1'b1;
    n = 0;
    while (!cpuAck && n < WaitLimit) begin
      @(posedge RESET);
      #1;
      n++;
    end
    if (!cpuAck) begin
      $display("timeout: no cpuAck for op %0d at address %h", s.op, s.addr);
      ok = 1'b0;
    end
    cpuReq = 1'b0;
    n = 0;
    while (cpuAck && n < WaitLimit) begin
      @(posedge RESET);
      #1;
      n++;
    end
    if (cpuAck) begin
      $display("timeout: cpuAck stayed high after cpuReq dropped at %h", s.addr);
      ok = 1'b0;
    end
  endtask

  // four-phase memory with a delay that depends on the line
  always @(posedge RESET) begin
    #1;
    if (!rstN) begin
      memAck = 1'b0;
      memWait = 0;
    end else if (memReq && !memAck) begin
      if (memWait < 2 + memCmd.lineAddr[1:0]) begin
        memWait++;
      end else begin
        memWait = 0;
        for (int b = 0; b < `LINE_BITS / 8; b++) begin
          if (memCmd.write) memBytes[{memCmd.lineAddr, offsetT'(b)}] = memCmd.wline[b*8 +: 8];
          else memRline[b*8 +: 8] = memBytes[{memCmd.lineAddr, offsetT'(b)}];
        end
        memAck = 1'b1;
      end
    end else if (!memReq && memAck) begin
      memAck = 1'b0;
    end
  end

  initial begin
    logic ok;
    RESET = 1'b0;
    rstN = 1'b0;
    cpuReq = 1'b0;
    cpuCmd = '0;
    memAck = 1'b0;
    memRline = '0;
    expKind = kAny;
    timeoutCount = 0;
    lfsr = 32'hbb1e;
    for (int a = 0; a < (1 << `ADDR_BITS); a++) begin
      memBytes[a] = fillByte(addrT'(a));
    end
    buildTable();
    repeat (8) @(posedge RESET);
    #1;
    rstN = 1'b1;
    for (int i = 0; i < stim.size() && timeoutCount == 0; i++) begin
      runAccess(stim[i], ok);
      if (!ok) timeoutCount++;
    end
    repeat (4) @(posedge RESET);
    $display("checks %0d, errors %0d, timeouts %0d", checkCount, errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0 && checkCount > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- cacheCtl.f
+incdir+src
src/cachePkg.sv
src/cacheWay.sv
src/hitSelect.sv
src/cacheCtrl.sv
src/cacheTop.sv
test/cacheChecker.sv
test/tbTop.sv

//--- run.sh
#!/bin/sh
# build the cache testbench with Verilator, run it, judge by the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tbTop -f cacheCtl.f -o simTb \
  && ./obj_dir/simTb > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^Test passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
